/* design/gpio_pkg.sv */
//////////////////////////////////////////////////////////////////////
// gpio controller shared definitions
// pin and bus widths, register map and configuration structs
//////////////////////////////////////////////////////////////////////

package gpio_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned GPIO_WIDTH = 16;  // number of pins
    localparam int unsigned ADDR_WIDTH = 3;   // register address bits
    localparam int unsigned BUS_WIDTH  = 32;  // bus data word

    typedef logic [GPIO_WIDTH-1:0] pin_vec_t;   // one bit per pin
    typedef logic [ADDR_WIDTH-1:0] reg_addr_t;  // register address
    typedef logic [BUS_WIDTH-1:0]  bus_data_t;  // pins in low bits, rest zero

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////

    typedef enum reg_addr_t {
        REG_OUT_EN     = 3'd0,  // output enable
        REG_OUT_DATA   = 3'd1,  // output data
        REG_IN_EN      = 3'd2,  // input enable
        REG_IN_DATA    = 3'd3,  // synchronized input, read only
        REG_IRQ_EN     = 3'd4,  // interrupt enable
        REG_IRQ_MODE   = 3'd5,  // 1 = edge, 0 = level
        REG_IRQ_POL    = 3'd6,  // 1 = high / rising
        REG_IRQ_STATUS = 3'd7   // read status, write 1 to clear
    } reg_addr_e;

    //////////////////////////////////////////////////////////////////////
    // grouped signals
    //////////////////////////////////////////////////////////////////////

    // per-pin interrupt configuration, 48 bits
    typedef struct packed {
        pin_vec_t ena;   // source enable
        pin_vec_t mode;  // level or edge
        pin_vec_t pol;   // active level / edge direction
    } irq_cfg_t;

    // bus write strobe with address and data, 36 bits
    typedef struct packed {
        logic      wen;  // write enable
        reg_addr_t wad;  // write address
        bus_data_t wdt;  // write data
    } bus_wr_t;

endpackage

/* design/gpio_regs.sv */
//////////////////////////////////////////////////////////////////////
// gpio register block
// six writable configuration registers, write decode,
// combinational read-back and the interrupt status clear strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_regs (
    input  logic                clk,
    input  logic                rst,
    // bus
    input  gpio_pkg::bus_wr_t   bus_wr,      // write strobe, address, data
    input  gpio_pkg::reg_addr_t rad,         // read address
    output gpio_pkg::bus_data_t rdt,         // read data, same cycle
    // pins
    output gpio_pkg::pin_vec_t  gpio_o,      // output data to pads
    output gpio_pkg::pin_vec_t  gpio_e,      // output enable to pads
    // input path
    output gpio_pkg::pin_vec_t  in_en,       // per-pin input enable
    input  gpio_pkg::pin_vec_t  in_data,     // synchronized input
    // interrupt logic
    output gpio_pkg::irq_cfg_t  irq_cfg,     // ena, mode, pol
    output gpio_pkg::pin_vec_t  status_clr,  // one-cycle clear strobe
    input  gpio_pkg::pin_vec_t  status       // interrupt status
);

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    gpio_pkg::pin_vec_t out_en_q;    // output enable
    gpio_pkg::pin_vec_t out_data_q;  // output data
    gpio_pkg::pin_vec_t in_en_q;     // input enable
    gpio_pkg::irq_cfg_t irq_cfg_q;   // interrupt config

    gpio_pkg::pin_vec_t wr_pins;     // write data cut to pin width

    assign wr_pins = gpio_pkg::pin_vec_t'(bus_wr.wdt);  // upper bits dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en_q   <= '0;
            out_data_q <= '0;
            in_en_q    <= '0;
            irq_cfg_q  <= '0;
        end else if (bus_wr.wen) begin
            case (gpio_pkg::reg_addr_e'(bus_wr.wad))
                gpio_pkg::REG_OUT_EN:   out_en_q       <= wr_pins;
                gpio_pkg::REG_OUT_DATA: out_data_q     <= wr_pins;
                gpio_pkg::REG_IN_EN:    in_en_q        <= wr_pins;
                gpio_pkg::REG_IRQ_EN:   irq_cfg_q.ena  <= wr_pins;
                gpio_pkg::REG_IRQ_MODE: irq_cfg_q.mode <= wr_pins;
                gpio_pkg::REG_IRQ_POL:  irq_cfg_q.pol  <= wr_pins;
                // input data is read only, status handled by the clear strobe
                default: ;
            endcase
        end
    end

    // straight from the registers
    assign gpio_o  = out_data_q;
    assign gpio_e  = out_en_q;
    assign in_en   = in_en_q;
    assign irq_cfg = irq_cfg_q;

    //////////////////////////////////////////////////////////////////////
    // status clear
    //////////////////////////////////////////////////////////////////////

    // write-1-to-clear, only during the write cycle itself
    always_comb begin
        if (bus_wr.wen && (bus_wr.wad == gpio_pkg::REG_IRQ_STATUS)) begin
            status_clr = wr_pins;
        end else begin
            status_clr = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read-back
    //////////////////////////////////////////////////////////////////////

    // pure decode of rad, no read strobe
    always_comb begin
        case (gpio_pkg::reg_addr_e'(rad))
            gpio_pkg::REG_OUT_EN:     rdt = gpio_pkg::bus_data_t'(out_en_q);
            gpio_pkg::REG_OUT_DATA:   rdt = gpio_pkg::bus_data_t'(out_data_q);
            gpio_pkg::REG_IN_EN:      rdt = gpio_pkg::bus_data_t'(in_en_q);
            gpio_pkg::REG_IN_DATA:    rdt = gpio_pkg::bus_data_t'(in_data);
            gpio_pkg::REG_IRQ_EN:     rdt = gpio_pkg::bus_data_t'(irq_cfg_q.ena);
            gpio_pkg::REG_IRQ_MODE:   rdt = gpio_pkg::bus_data_t'(irq_cfg_q.mode);
            gpio_pkg::REG_IRQ_POL:    rdt = gpio_pkg::bus_data_t'(irq_cfg_q.pol);
            gpio_pkg::REG_IRQ_STATUS: rdt = gpio_pkg::bus_data_t'(status);
            default:                  rdt = '0;
        endcase
    end

endmodule

/* design/gpio_input_sync.sv */
//////////////////////////////////////////////////////////////////////
// gpio input synchronizer
// SYNC_STAGES flop ranks per pin, gated by input enable,
// or a plain bypass when SYNC_STAGES is 0
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_input_sync #(
    parameter int unsigned SYNC_STAGES = 2  // 0 = bypass, else 2 or more
) (
    input  logic               clk,
    input  logic               rst,
    input  gpio_pkg::pin_vec_t gpio_i,   // raw pad inputs
    input  gpio_pkg::pin_vec_t in_en,    // per-pin enable
    output gpio_pkg::pin_vec_t in_data   // synchronized, disabled pins 0
);

    generate
        if (SYNC_STAGES == 0) begin : gen_bypass
            // sync done outside, just gate
            assign in_data = gpio_i & in_en;
        end else if (SYNC_STAGES == 1) begin : gen_bad_depth
            $error("gpio_input_sync: a single synchronizer stage is not supported");
            assign in_data = '0;
        end else begin : gen_sync
            gpio_pkg::pin_vec_t sync_q [SYNC_STAGES];  // rank 0 faces the pads

            for (genvar k = 0; k < SYNC_STAGES; k++) begin : gen_rank
                gpio_pkg::pin_vec_t src;  // rank input

                if (k == 0) begin : gen_first
                    assign src = gpio_i;
                end else begin : gen_next
                    assign src = sync_q[k-1];
                end

                // disabled pins hold, saves toggling
                always_ff @(posedge clk or posedge rst) begin
                    if (rst) begin
                        sync_q[k] <= '0;
                    end else begin
                        sync_q[k] <= (src & in_en) | (sync_q[k] & ~in_en);
                    end
                end
            end

            // held value hidden while disabled
            assign in_data = sync_q[SYNC_STAGES-1] & in_en;
        end
    endgenerate

endmodule

/* design/gpio_irq.sv */
//////////////////////////////////////////////////////////////////////
// gpio interrupt logic
// polarity and enable, edge detect with sticky status,
// level/edge select per pin and the masked irq OR
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_irq #(
    parameter gpio_pkg::pin_vec_t IRQ_MASK = '1  // pins with irq hardware
) (
    input  logic               clk,
    input  logic               rst,
    input  gpio_pkg::pin_vec_t in_data,     // synchronized pins
    input  gpio_pkg::irq_cfg_t irq_cfg,     // ena, mode, pol
    input  gpio_pkg::pin_vec_t status_clr,  // write-1-to-clear strobe
    output gpio_pkg::pin_vec_t status,      // per-pin status
    output logic               irq          // single interrupt line
);

    gpio_pkg::pin_vec_t act_val;   // polarity adjusted, enabled
    gpio_pkg::pin_vec_t act_dly;   // previous act_val, edge pins only
    gpio_pkg::pin_vec_t rise;      // 0 -> 1 of act_val
    gpio_pkg::pin_vec_t edge_q;    // sticky edge status
    gpio_pkg::pin_vec_t raw_sts;   // level or edge, before mask

    //////////////////////////////////////////////////////////////////////
    // active value
    //////////////////////////////////////////////////////////////////////

    // pol 0 inverts so low / falling looks like high / rising
    assign act_val = (in_data ^ ~irq_cfg.pol) & irq_cfg.ena;

    //////////////////////////////////////////////////////////////////////
    // edge detection
    //////////////////////////////////////////////////////////////////////

    // level-mode pins never toggle the delay flops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_dly <= '0;
        end else begin
            act_dly <= act_val & irq_cfg.mode;
        end
    end

    assign rise = act_val & ~act_dly & irq_cfg.mode & IRQ_MASK;

    // set beats clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            edge_q <= '0;
        end else begin
            edge_q <= (edge_q & ~status_clr) | rise;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // status and irq
    //////////////////////////////////////////////////////////////////////

    // level status is live, edge status latched
    assign raw_sts = (act_val & ~irq_cfg.mode) | (edge_q & irq_cfg.mode);

    assign status = raw_sts & IRQ_MASK;  // unimplemented pins read 0
    assign irq    = |status;

endmodule

/* design/gpio_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// gpio controller top level
// register block beside the input synchronizer and irq logic
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_ctrl #(
    parameter int unsigned        SYNC_STAGES = 2,   // 0 = bypass
    parameter gpio_pkg::pin_vec_t IRQ_MASK    = '1   // pins with irq hardware
) (
    input  logic                clk,
    input  logic                rst,
    // bus
    input  gpio_pkg::bus_wr_t   bus_wr,  // write port
    input  gpio_pkg::reg_addr_t rad,     // read address
    output gpio_pkg::bus_data_t rdt,     // read data
    // pads
    output gpio_pkg::pin_vec_t  gpio_o,  // output data
    output gpio_pkg::pin_vec_t  gpio_e,  // output enable
    input  gpio_pkg::pin_vec_t  gpio_i,  // pad inputs
    // interrupt
    output logic                irq
);

    gpio_pkg::pin_vec_t in_en;       // input enable
    gpio_pkg::pin_vec_t in_data;     // synchronized inputs
    gpio_pkg::irq_cfg_t irq_cfg;     // interrupt configuration
    gpio_pkg::pin_vec_t status_clr;  // status clear strobe
    gpio_pkg::pin_vec_t status;      // interrupt status

    //////////////////////////////////////////////////////////////////////
    // register block
    //////////////////////////////////////////////////////////////////////

    gpio_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .bus_wr     (bus_wr),
        .rad        (rad),
        .rdt        (rdt),
        .gpio_o     (gpio_o),
        .gpio_e     (gpio_e),
        .in_en      (in_en),
        .irq_cfg    (irq_cfg),
        .status_clr (status_clr),
        .in_data    (in_data),
        .status     (status)
    );

    //////////////////////////////////////////////////////////////////////
    // pin inputs and interrupts
    //////////////////////////////////////////////////////////////////////

    gpio_input_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_input_sync (
        .clk     (clk),
        .rst     (rst),
        .gpio_i  (gpio_i),
        .in_en   (in_en),
        .in_data (in_data)
    );

    gpio_irq #(
        .IRQ_MASK (IRQ_MASK)
    ) u_irq (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .irq_cfg    (irq_cfg),
        .status_clr (status_clr),
        .status     (status),
        .irq        (irq)
    );

endmodule

/* tb/gpio_ctrl_sva.sv */
//////////////////////////////////////////////////////////////////////
// gpio controller assertions
// reset quiet, irq against level rule and edge status,
// gpio_e against writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_ctrl_sva #(
    parameter gpio_pkg::pin_vec_t IRQ_MASK = '1
) (
    input logic               clk,
    input logic               rst,
    input gpio_pkg::bus_wr_t  bus_wr,
    input gpio_pkg::pin_vec_t gpio_e,
    input gpio_pkg::pin_vec_t in_data,  // synchronized pins
    input gpio_pkg::irq_cfg_t irq_cfg,  // ena, mode, pol
    input gpio_pkg::pin_vec_t status,   // internal status of the DUT
    input logic               irq
);

    gpio_pkg::pin_vec_t out_en_model;  // last value written to REG_OUT_EN
    gpio_pkg::pin_vec_t level_model;   // level sources at their active level

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en_model <= '0;
        end else if (bus_wr.wen && (bus_wr.wad == gpio_pkg::REG_OUT_EN)) begin
            out_en_model <= bus_wr.wdt[gpio_pkg::GPIO_WIDTH-1:0];  // low bits only
        end
    end

    // pol 1 active high, pol 0 active low
    always_comb begin
        for (int p = 0; p < gpio_pkg::GPIO_WIDTH; p++) begin
            level_model[p] = irq_cfg.ena[p] && !irq_cfg.mode[p]
                             && (in_data[p] == irq_cfg.pol[p]);
        end
    end

    // negedge so the first reset edge has already cleared the flops
    a_reset_quiet: assert property (@(negedge clk) rst |-> (irq == 1'b0 && gpio_e == '0))
        else $error("irq or gpio_e active during reset");

    // edge pins through the latched status
    a_irq_or: assert property (@(posedge clk) disable iff (rst)
        irq == |((level_model | (status & irq_cfg.mode)) & IRQ_MASK))
        else $error("irq does not match the level rule and the edge status");

    a_out_en: assert property (@(posedge clk) disable iff (rst) gpio_e == out_en_model)
        else $error("gpio_e differs from the last REG_OUT_EN write");

endmodule

bind gpio_ctrl gpio_ctrl_sva #(.IRQ_MASK(IRQ_MASK)) u_sva (
    .clk     (clk),
    .rst     (rst),
    .bus_wr  (bus_wr),
    .gpio_e  (gpio_e),
    .in_data (in_data),
    .irq_cfg (irq_cfg),
    .status  (status),
    .irq     (irq)
);

/* tb/tb_gpio_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// gpio controller testbench
// runs the stimulus file commands against the DUT, checks read data,
// pins and irq, prints one line per test and the closing counts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_gpio_ctrl;

    localparam int MAX_CYCLES = 2000;  // ~75 commands, at most ~10 cycles each, wide margin

    logic                clk;
    logic                rst;
    gpio_pkg::bus_wr_t   bus_wr;
    gpio_pkg::reg_addr_t rad;
    gpio_pkg::bus_data_t rdt;
    gpio_pkg::pin_vec_t  gpio_o;
    gpio_pkg::pin_vec_t  gpio_e;
    gpio_pkg::pin_vec_t  gpio_i;
    logic                irq;

    int               fd;           // stimulus file handle
    logic [8*8-1:0]   cmd;          // command token
    logic [8*32-1:0]  test_name;
    logic [8*128-1:0] line_buf;     // swallowed comment text
    integer           seed;         // $random state
    int               cycle_count;
    int               checks;
    int               errors;
    int               tests;
    int               test_errors;  // errors in the running test

    gpio_ctrl #(
        .SYNC_STAGES (2),
        .IRQ_MASK    (16'h7FFF)  // pin 15 without irq hardware
    ) u_dut (
        .clk    (clk),
        .rst    (rst),
        .bus_wr (bus_wr),
        .rad    (rad),
        .rdt    (rdt),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    ////////////////////////////////////////////////////////////////////////
    // check and report helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %0s %0s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic bad_line();
        $display("stimulus line for command %0s has missing or bad operands", cmd);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test();
        if (tests > 0) begin
            $display("test %0s finished, %0d error(s)", test_name, test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // bus and pin drivers
    ////////////////////////////////////////////////////////////////////////

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus_wr.wen <= 1'b1;
        bus_wr.wad <= gpio_pkg::reg_addr_t'(addr);
        bus_wr.wdt <= data;
        @(posedge clk);  // register loads here
        bus_wr.wen <= 1'b0;
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk);
        rad <= gpio_pkg::reg_addr_t'(addr);
        @(negedge clk);  // rdt settled
        check_value($sformatf("read addr %0d", addr), exp, rdt);
    endtask

    task automatic drive_pins(input logic [31:0] pins);
        @(posedge clk);
        gpio_i <= gpio_pkg::pin_vec_t'(pins);
        repeat (2) @(posedge clk);  // two sync ranks
    endtask

    // only the low 16 bits are kept by a register
    task automatic random_readback(input logic [31:0] addr);
        logic [31:0] rnd;
        logic [31:0] exp;
        rnd = $random(seed);
        exp = {16'h0000, rnd[15:0]};
        bus_write(addr, rnd);
        read_check(addr, exp);
        if (addr == 32'd0) begin
            check_value("gpio_e", exp, gpio_pkg::bus_data_t'(gpio_e));
        end else if (addr == 32'd1) begin
            check_value("gpio_o", exp, gpio_pkg::bus_data_t'(gpio_o));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////////////////

    task automatic run_command();
        logic [31:0] op_a;
        logic [31:0] op_b;
        int          n;
        case (cmd)
            "#": n = $fgets(line_buf, fd);  // comment line
            "T": begin
                finish_test();
                n = $fscanf(fd, "%s", test_name);
                tests++;
                test_errors = 0;
            end
            "W": begin
                n = $fscanf(fd, "%h %h", op_a, op_b);
                if (n == 2) bus_write(op_a, op_b);
                else bad_line();
            end
            "R": begin
                n = $fscanf(fd, "%h %h", op_a, op_b);
                if (n == 2) read_check(op_a, op_b);
                else bad_line();
            end
            "P": begin
                n = $fscanf(fd, "%h", op_a);
                if (n == 1) drive_pins(op_a);
                else bad_line();
            end
            "Q": begin
                n = $fscanf(fd, "%h", op_a);
                @(negedge clk);
                if (n == 1) check_value("irq", op_a, {31'd0, irq});
                else bad_line();
            end
            "G": begin
                n = $fscanf(fd, "%h %h", op_a, op_b);
                @(negedge clk);
                if (n == 2) begin
                    check_value("gpio_o", op_a, gpio_pkg::bus_data_t'(gpio_o));
                    check_value("gpio_e", op_b, gpio_pkg::bus_data_t'(gpio_e));
                end else begin
                    bad_line();
                end
            end
            "C": begin
                n = $fscanf(fd, "%d", op_a);
                if (n == 1) repeat (op_a) @(posedge clk);
                else bad_line();
            end
            "N": begin
                n = $fscanf(fd, "%h", op_a);
                if (n == 1) random_readback(op_a);
                else bad_line();
            end
            default: begin
                $display("unknown stimulus command %0s", cmd);
                errors++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence and timeout
    ////////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        bus_wr      = '0;
        rad         = '0;
        gpio_i      = '0;
        seed        = 58038;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        test_errors = 0;
        test_name   = "none";
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("tb/gpio_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/gpio_stimulus.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                run_command();
            end
            $fclose(fd);
            finish_test();
        end
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* tb/gpio_stimulus.txt */
# cmd then hex operands: T name | W addr data | R addr expect | P pins
# Q irq | G gpio_o gpio_e | C cycles (decimal) | N addr (random write, read back)
T reset_values
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
R 6 00000000
R 7 00000000
G 0000 0000
Q 0
T reg_readback
W 0 0000a5c3
W 1 ffff3c5a
R 1 00003c5a
G 3c5a a5c3
W 5 0000abcd
W 6 ffff00f0
W 4 00001234
R 4 00001234
R 5 0000abcd
R 6 000000f0
W 3 0000ffff
R 0 0000a5c3
T random_readback
N 0
N 1
N 2
T input_path
W 2 0000ffff
P 0000a55a
R 3 0000a55a
W 2 000000ff
P 00005aa5
R 3 000000a5
W 2 0000ffff
C 2
R 3 00005aa5
T level_irq
W 5 00000000
W 6 0000ffff
P 00000000
W 4 0000ffff
Q 0
P 00000011
Q 1
R 7 00000011
P 00008000
Q 0
W 6 0000fffe
Q 1
R 7 00000001
T edge_irq
W 4 00000000
W 5 0000ffff
W 6 000000ff
P 0000ff00
W 7 0000ffff
W 4 0000ffff
P 0000ff04
C 1
Q 1
P 0000fb00
C 1
R 7 00000404
W 7 00000004
R 7 00000400
W 7 00000400
Q 0
P 00007b00
C 1
Q 0

/* gpio_ctrl.f */
design/gpio_pkg.sv
design/gpio_regs.sv
design/gpio_input_sync.sv
design/gpio_irq.sv
design/gpio_ctrl.sv
tb/gpio_ctrl_sva.sv
tb/tb_gpio_ctrl.sv

/* run_sim.sh */
#!/bin/bash
# build the gpio controller testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_gpio_ctrl \
    -f gpio_ctrl.f -o tb_gpio_ctrl > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
# a stop on an assertion or a crash ends without a closing line
{ ./obj_dir/tb_gpio_ctrl || echo "Done: errors found"; } > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
